//--- include/micro_rom_image.svh
/*
 * microcode ROM image, one case item per micro word
 * included inside the address case of the ROM lookup
 */
`ifndef MICRO_ROM_IMAGE_SVH
`define MICRO_ROM_IMAGE_SVH

// invalid opcode: save state, then trap
ent_invalid:        uword = '{uop: uop_push,       end_seq: 1'b0, div: 1'b0};
ent_invalid + 6'd1: uword = '{uop: uop_trap,       end_seq: 1'b1, div: 1'b0};
ent_nop:            uword = '{uop: uop_idle,       end_seq: 1'b1, div: 1'b0};
ent_mov_ri:         uword = '{uop: uop_load_imm,   end_seq: 1'b1, div: 1'b0};
ent_mov_rm:         uword = '{uop: uop_fetch_opnd, end_seq: 1'b0, div: 1'b0};
ent_mov_rm + 6'd1:  uword = '{uop: uop_move,       end_seq: 1'b1, div: 1'b0};
ent_alu_rm:         uword = '{uop: uop_fetch_opnd, end_seq: 1'b0, div: 1'b0};
ent_alu_rm + 6'd1:  uword = '{uop: uop_alu,        end_seq: 1'b0, div: 1'b0};
ent_alu_rm + 6'd2:  uword = '{uop: uop_move,       end_seq: 1'b1, div: 1'b0};
ent_alu_acc:        uword = '{uop: uop_load_imm,   end_seq: 1'b0, div: 1'b0};
ent_alu_acc + 6'd1: uword = '{uop: uop_alu,        end_seq: 1'b1, div: 1'b0};
ent_grp1:           uword = '{uop: uop_fetch_opnd, end_seq: 1'b0, div: 1'b0};
ent_grp1 + 6'd1:    uword = '{uop: uop_load_imm,   end_seq: 1'b0, div: 1'b0};
ent_grp1 + 6'd2:    uword = '{uop: uop_alu,        end_seq: 1'b1, div: 1'b0};
ent_grp3:           uword = '{uop: uop_fetch_opnd, end_seq: 1'b0, div: 1'b0};
ent_grp3 + 6'd1:    uword = '{uop: uop_alu,        end_seq: 1'b1, div: 1'b0};
// divide: middle word stalls while the divider iterates
ent_div:            uword = '{uop: uop_fetch_opnd, end_seq: 1'b0, div: 1'b1};
ent_div + 6'd1:     uword = '{uop: uop_div_step,   end_seq: 1'b0, div: 1'b1};
ent_div + 6'd2:     uword = '{uop: uop_move,       end_seq: 1'b1, div: 1'b1};
ent_jmp:            uword = '{uop: uop_load_imm,   end_seq: 1'b0, div: 1'b0};
ent_jmp + 6'd1:     uword = '{uop: uop_branch,     end_seq: 1'b1, div: 1'b0};
// interrupt entries push flags, cs, ip and branch to the vector
ent_eint:           uword = '{uop: uop_push,       end_seq: 1'b0, div: 1'b0};
ent_eint + 6'd1:    uword = '{uop: uop_push,       end_seq: 1'b0, div: 1'b0};
ent_eint + 6'd2:    uword = '{uop: uop_push,       end_seq: 1'b0, div: 1'b0};
ent_eint + 6'd3:    uword = '{uop: uop_branch,     end_seq: 1'b1, div: 1'b0};
ent_eintp:          uword = '{uop: uop_push,       end_seq: 1'b0, div: 1'b0};
ent_eintp + 6'd1:   uword = '{uop: uop_push,       end_seq: 1'b0, div: 1'b0};
ent_eintp + 6'd2:   uword = '{uop: uop_push,       end_seq: 1'b0, div: 1'b0};
ent_eintp + 6'd3:   uword = '{uop: uop_branch,     end_seq: 1'b1, div: 1'b0};
ent_intd:           uword = '{uop: uop_push,       end_seq: 1'b0, div: 1'b0};
ent_intd + 6'd1:    uword = '{uop: uop_push,       end_seq: 1'b0, div: 1'b0};
ent_intd + 6'd2:    uword = '{uop: uop_push,       end_seq: 1'b0, div: 1'b0};
ent_intd + 6'd3:    uword = '{uop: uop_branch,     end_seq: 1'b1, div: 1'b0};

`endif

//--- src/x86_isa_pkg.sv
/*
 * instruction-set definitions shared by the decode stage
 * opcode classes, segment and register codes, operand structs
 */
`default_nettype none

package x86_isa_pkg;

  // instruction classes of the decoded subset
  typedef enum logic [3:0] {
    cls_invalid,
    cls_nop,
    cls_mov_ri,
    cls_mov_rm,
    cls_alu_rm,
    cls_alu_acc,
    cls_grp1,
    cls_grp3,
    cls_div,
    cls_jmp
  } op_class_t;

  // segment register encodings
  typedef enum logic [1:0] {
    es = 2'd0,
    cs = 2'd1,
    ss = 2'd2,
    ds = 2'd3
  } seg_t;

  // 16-bit general registers used by effective addressing
  localparam logic [3:0] reg_bx   = 4'd3;
  localparam logic [3:0] reg_bp   = 4'd5;
  localparam logic [3:0] reg_si   = 4'd6;
  localparam logic [3:0] reg_di   = 4'd7;
  // no register in this slot
  localparam logic [3:0] reg_none = 4'd15;

  // which operand bytes fetch still has to supply
  typedef struct packed {
    logic need_modrm;
    logic need_off;
    logic need_imm;
    logic off_size;
    logic imm_size;
  } operand_need_t;

  // register and segment selection for the execution unit
  typedef struct packed {
    logic [3:0] src;
    logic [3:0] dst;
    logic [3:0] base;
    logic [3:0] index;
    seg_t       seg;
  } operand_fields_t;

endpackage

`default_nettype wire

//--- src/micro_seq_pkg.sv
/*
 * microcode definitions: address width, sequence entries,
 * divide stall length and the micro-word layout
 */
`default_nettype none

package micro_seq_pkg;

  localparam int micro_addr_width = 6;

  typedef logic [micro_addr_width-1:0] micro_addr_t;

  // sequence entry points, one per class plus redirects
  localparam micro_addr_t ent_invalid = 6'd0;
  localparam micro_addr_t ent_nop     = 6'd2;
  localparam micro_addr_t ent_mov_ri  = 6'd3;
  localparam micro_addr_t ent_mov_rm  = 6'd4;
  localparam micro_addr_t ent_alu_rm  = 6'd6;
  localparam micro_addr_t ent_alu_acc = 6'd9;
  localparam micro_addr_t ent_grp1    = 6'd11;
  localparam micro_addr_t ent_grp3    = 6'd14;
  localparam micro_addr_t ent_div     = 6'd16;
  localparam micro_addr_t ent_jmp     = 6'd19;
  // external interrupt, plain and with rep pending
  localparam micro_addr_t ent_eint    = 6'd21;
  localparam micro_addr_t ent_eintp   = 6'd25;
  // divide-error trap
  localparam micro_addr_t ent_intd    = 6'd29;

  // cycles the divider holds the middle div word
  localparam logic [4:0] div_stall = 5'd18;

  typedef enum logic [3:0] {
    uop_idle,
    uop_fetch_opnd,
    uop_alu,
    uop_move,
    uop_load_imm,
    uop_branch,
    uop_push,
    uop_div_step,
    uop_trap
  } uop_t;

  typedef struct packed {
    uop_t uop;
    logic end_seq;
    logic div;
  } micro_word_t;

endpackage

`default_nettype wire

//--- src/opcode_deco.sv
/*
 * combinational opcode classifier: class entry address,
 * operand bytes still to fetch and register/segment fields
 */
`timescale 1ns/1ps
`default_nettype none

module opcode_deco (
  input  logic [7:0]                    opcode,
  input  logic [7:0]                    modrm,
  input  logic                          rep,
  input  logic [2:0]                    sop_l,
  output micro_seq_pkg::micro_addr_t    base_addr,
  output x86_isa_pkg::operand_need_t    need,
  output x86_isa_pkg::operand_fields_t  fields
);
  import x86_isa_pkg::*;
  import micro_seq_pkg::*;

  op_class_t  cls;
  logic [1:0] md;
  logic [2:0] rg;
  logic [2:0] rm;
  logic       has_modrm;
  logic       bp_based;

  // modrm split
  assign md = modrm[7:6];
  assign rg = modrm[5:3];
  assign rm = modrm[2:0];

  always_comb begin
    casez (opcode)
      8'b00??_?0??: cls = cls_alu_rm;
      8'b00??_?10?: cls = cls_alu_acc;
      8'b1000_00??: cls = cls_grp1;
      8'b1000_10??: cls = cls_mov_rm;
      8'b1011_????: cls = cls_mov_ri;
      8'b1111_011?: cls = cls_grp3;
      8'h90:        cls = cls_nop;
      8'heb:        cls = cls_jmp;
      default:      cls = cls_invalid;
    endcase
    // div and idiv live in group 3, reg 6 and 7
    if (cls == cls_grp3 && rg[2:1] == 2'b11) begin
      cls = cls_div;
    end
  end

  // class to microcode entry
  always_comb begin
    case (cls)
      cls_nop:     base_addr = ent_nop;
      cls_mov_ri:  base_addr = ent_mov_ri;
      cls_mov_rm:  base_addr = ent_mov_rm;
      cls_alu_rm:  base_addr = ent_alu_rm;
      cls_alu_acc: base_addr = ent_alu_acc;
      cls_grp1:    base_addr = ent_grp1;
      cls_grp3:    base_addr = ent_grp3;
      cls_div:     base_addr = ent_div;
      cls_jmp:     base_addr = ent_jmp;
      default:     base_addr = ent_invalid;
    endcase
  end

  assign has_modrm = cls inside {cls_mov_rm, cls_alu_rm, cls_grp1, cls_grp3, cls_div};

  // displacement only exists behind a modrm byte
  assign need.need_modrm = has_modrm;
  assign need.need_off   = has_modrm & (md == 2'b01 || md == 2'b10
                                        || (md == 2'b00 && rm == 3'b110));
  assign need.off_size   = (md != 2'b01);
  assign need.need_imm   = cls inside {cls_alu_acc, cls_mov_ri, cls_grp1, cls_jmp};
  // sign-extended imm8 for 83 and the short jump
  assign need.imm_size   = (cls == cls_mov_ri ? opcode[3] : opcode[0])
                           & ~(opcode == 8'h83 || opcode == 8'heb);

  // d bit set means reg is the destination
  assign fields.src = opcode[1] ? {1'b0, rm} : {1'b0, rg};
  assign fields.dst = opcode[1] ? {1'b0, rg} : {1'b0, rm};

  // 16-bit effective address table
  always_comb begin
    fields.base  = reg_none;
    fields.index = reg_none;
    bp_based     = 1'b0;
    if (md != 2'b11) begin
      case (rm)
        3'd0: begin fields.base = reg_bx; fields.index = reg_si; end
        3'd1: begin fields.base = reg_bx; fields.index = reg_di; end
        3'd2: begin fields.base = reg_bp; fields.index = reg_si; bp_based = 1'b1; end
        3'd3: begin fields.base = reg_bp; fields.index = reg_di; bp_based = 1'b1; end
        3'd4: fields.base = reg_si;
        3'd5: fields.base = reg_di;
        // mod 00 here is a direct address
        3'd6: begin
          if (md != 2'b00) begin
            fields.base = reg_bp;
            bp_based    = 1'b1;
          end
        end
        default: fields.base = reg_bx;
      endcase
    end
  end

  // override wins, else ss for bp forms
  assign fields.seg = sop_l[2] ? seg_t'(sop_l[1:0]) : (bp_based ? ss : ds);

endmodule

`default_nettype wire

//--- src/instr_decode.sv
/*
 * micro-sequencer: offset counter, divide stall, divide-error and
 * external interrupt redirects, interrupt acknowledge and alu field
 */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [7:0]                  opcode,
  input  logic [7:0]                  modrm,
  input  logic                        rep,
  input  logic                        exec_st,
  input  logic                        block,
  input  logic                        div_exc,
  input  logic                        intr,
  input  logic                        ifl,
  input  logic                        end_seq,
  input  logic                        div,
  input  micro_seq_pkg::micro_addr_t  base_addr,
  output micro_seq_pkg::micro_addr_t  seq_addr,
  output logic [2:0]                  f,
  output logic                        inta,
  output logic                        ext_int
);
  import micro_seq_pkg::*;

  micro_addr_t seq_off;
  micro_addr_t redir_base;
  logic [4:0]  div_cnt;
  logic        dive;
  logic        ext_int_q;

  // divide error first, then interrupt, then the class entry
  assign redir_base = dive ? ent_intd : (ext_int ? (rep ? ent_eintp : ent_eint) : base_addr);
  assign seq_addr   = redir_base + seq_off;

  // group forms carry the alu op in modrm reg
  assign f = opcode[7] ? modrm[5:3] : opcode[5:3];

  // offset within the running sequence
  always_ff @(posedge clk) begin
    if (rst) begin
      seq_off <= '0;
    end else if (block) begin
      seq_off <= seq_off;
    end else if (end_seq) begin
      seq_off <= '0;
    end else if (div_cnt != 5'd0) begin
      // divider still iterating
      seq_off <= seq_off;
    end else if (exec_st) begin
      seq_off <= seq_off + micro_addr_t'(1);
    end else begin
      seq_off <= '0;
    end
  end

  // stall counter, reloads on each div word
  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= 5'd0;
    end else if (div && exec_st) begin
      div_cnt <= (div_cnt == 5'd0) ? div_stall : div_cnt - 5'd1;
    end else begin
      div_cnt <= 5'd0;
    end
  end

  // divide-error redirect, kept until its sequence ends
  always_ff @(posedge clk) begin
    if (rst) begin
      dive <= 1'b0;
    end else if (!block) begin
      dive <= div_exc | (dive & ~end_seq);
    end
  end

  // interrupt taken only at an instruction boundary
  always_ff @(posedge clk) begin
    if (rst) begin
      ext_int <= 1'b0;
    end else if (!block) begin
      ext_int <= (intr & ifl & exec_st & end_seq) | (ext_int & ~end_seq);
    end
  end

  // one-cycle acknowledge on the rise of ext_int
  always_ff @(posedge clk) begin
    if (rst) begin
      ext_int_q <= 1'b0;
      inta      <= 1'b0;
    end else begin
      ext_int_q <= ext_int;
      inta      <= ext_int & ~ext_int_q;
    end
  end

endmodule

`default_nettype wire

//--- src/micro_rom.sv
/*
 * microcode ROM with asynchronous read
 * contents come from the included image file
 */
`timescale 1ns/1ps
`default_nettype none

module micro_rom (
  input  micro_seq_pkg::micro_addr_t  addr,
  output micro_seq_pkg::micro_word_t  uword
);
  import micro_seq_pkg::*;

  // plain lookup, no clock
  always_comb begin
    case (addr)
      `include "micro_rom_image.svh"
      // empty slot ends the walk at once
      default: uword = '{uop: uop_idle, end_seq: 1'b1, div: 1'b0};
    endcase
  end

endmodule

`default_nettype wire

//--- src/decode_top.sv
/*
 * decode stage top: classifier, sequencer and microcode ROM
 * rom end and div bits loop back into the sequencer
 */
`timescale 1ns/1ps
`default_nettype none

module decode_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [7:0]                    opcode,
  input  logic [7:0]                    modrm,
  input  logic                          rep,
  input  logic [2:0]                    sop_l,
  input  logic                          exec_st,
  input  logic                          block,
  input  logic                          div_exc,
  input  logic                          intr,
  input  logic                          ifl,
  output x86_isa_pkg::operand_need_t    need,
  output x86_isa_pkg::operand_fields_t  fields,
  output logic [2:0]                    f,
  output micro_seq_pkg::micro_addr_t    seq_addr,
  output micro_seq_pkg::micro_word_t    uword,
  output logic                          inta,
  output logic                          ext_int
);
  import micro_seq_pkg::*;

  // class entry from the classifier
  micro_addr_t base_addr;

  opcode_deco opcode_deco_i (
    .opcode    (opcode),
    .modrm     (modrm),
    .rep       (rep),
    .sop_l     (sop_l),
    .base_addr (base_addr),
    .need      (need),
    .fields    (fields)
  );

  instr_decode instr_decode_i (
    .clk       (clk),
    .rst       (rst),
    .opcode    (opcode),
    .modrm     (modrm),
    .rep       (rep),
    .exec_st   (exec_st),
    .block     (block),
    .div_exc   (div_exc),
    .intr      (intr),
    .ifl       (ifl),
    .end_seq   (uword.end_seq),
    .div       (uword.div),
    .base_addr (base_addr),
    .seq_addr  (seq_addr),
    .f         (f),
    .inta      (inta),
    .ext_int   (ext_int)
  );

  micro_rom micro_rom_i (
    .addr  (seq_addr),
    .uword (uword)
  );

endmodule

`default_nettype wire

//--- tests/decode_checker.sv
/*
 * monitor of the decode stage with a reference decode and sequencer model
 * compares the DUT ports on every rising clock edge
 */
`timescale 1ns/1ps
`default_nettype none

module decode_checker (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [7:0]                    opcode,
  input  logic [7:0]                    modrm,
  input  logic                          rep,
  input  logic [2:0]                    sop_l,
  input  logic                          exec_st,
  input  logic                          block,
  input  logic                          div_exc,
  input  logic                          intr,
  input  logic                          ifl,
  input  x86_isa_pkg::operand_need_t    need,
  input  x86_isa_pkg::operand_fields_t  fields,
  input  logic [2:0]                    f,
  input  micro_seq_pkg::micro_addr_t    seq_addr,
  input  micro_seq_pkg::micro_word_t    uword,
  input  logic                          inta,
  input  logic                          ext_int,
  output int                            err_cnt,
  output int                            chk_cnt
);
  import x86_isa_pkg::*;
  import micro_seq_pkg::*;

  typedef struct packed {
    op_class_t       cls;
    micro_addr_t     entry;
    operand_need_t   need;
    operand_fields_t fields;
    logic [2:0]      f;
  } ref_decode_t;

  // entry and word count of every sequence
  localparam micro_addr_t seq_entry [13] = '{ent_invalid, ent_nop, ent_mov_ri, ent_mov_rm,
    ent_alu_rm, ent_alu_acc, ent_grp1, ent_grp3, ent_div, ent_jmp, ent_eint, ent_eintp,
    ent_intd};
  localparam int seq_words [13] = '{2, 1, 1, 2, 3, 2, 3, 2, 3, 2, 4, 4, 4};

  int          errs = 0;
  int          checks = 0;
  // model state
  micro_addr_t m_off;
  logic [4:0]  m_cnt;
  logic        m_dive;
  logic        m_ext;
  logic        m_ext_q;
  logic        m_inta;
  // expected values of this cycle
  ref_decode_t exp_dec;
  micro_addr_t exp_base;
  micro_addr_t exp_addr;
  logic        exp_end;
  logic        exp_div;

  assign err_cnt = errs;
  assign chk_cnt = checks;

  // last word of a sequence, or an empty slot past the image
  function automatic logic last_word(micro_addr_t a);
    logic hit;
    int   i;
    hit = (a > ent_intd + 6'd3);
    for (i = 0; i < 13; i++) begin
      if (a == seq_entry[i] + micro_addr_t'(seq_words[i] - 1)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic logic div_word(micro_addr_t a);
    return (a >= ent_div) && (a < ent_div + 6'd3);
  endfunction

  function automatic ref_decode_t ref_decode(logic [7:0] op, logic [7:0] mrm, logic [2:0] sop);
    ref_decode_t r;
    logic [1:0]  md;
    logic [2:0]  rg;
    logic [2:0]  rm;
    logic        bp;
    md = mrm[7:6];
    rg = mrm[5:3];
    rm = mrm[2:0];
    r  = '0;
    bp = 1'b0;
    // class from opcode ranges
    if (op[7:6] == 2'b00 && op[2] == 1'b0)
      r.cls = cls_alu_rm;
    else if (op[7:6] == 2'b00 && op[2:1] == 2'b10)
      r.cls = cls_alu_acc;
    else if (op inside {[8'h80:8'h83]})
      r.cls = cls_grp1;
    else if (op inside {[8'h88:8'h8b]})
      r.cls = cls_mov_rm;
    else if (op inside {[8'hb0:8'hbf]})
      r.cls = cls_mov_ri;
    else if (op == 8'hf6 || op == 8'hf7)
      r.cls = (rg >= 3'd6) ? cls_div : cls_grp3;
    else if (op == 8'h90)
      r.cls = cls_nop;
    else if (op == 8'heb)
      r.cls = cls_jmp;
    else
      r.cls = cls_invalid;
    case (r.cls)
      cls_nop:     r.entry = ent_nop;
      cls_mov_ri:  r.entry = ent_mov_ri;
      cls_mov_rm:  r.entry = ent_mov_rm;
      cls_alu_rm:  r.entry = ent_alu_rm;
      cls_alu_acc: r.entry = ent_alu_acc;
      cls_grp1:    r.entry = ent_grp1;
      cls_grp3:    r.entry = ent_grp3;
      cls_div:     r.entry = ent_div;
      cls_jmp:     r.entry = ent_jmp;
      default:     r.entry = ent_invalid;
    endcase
    r.need.need_modrm = r.cls inside {cls_mov_rm, cls_alu_rm, cls_grp1, cls_grp3, cls_div};
    r.need.need_off   = r.need.need_modrm &&
                        (md == 2'b01 || md == 2'b10 || (md == 2'b00 && rm == 3'd6));
    r.need.off_size   = (md != 2'b01);
    r.need.need_imm   = r.cls inside {cls_alu_acc, cls_mov_ri, cls_grp1, cls_jmp};
    if (op == 8'h83 || op == 8'heb)
      r.need.imm_size = 1'b0;
    else
      r.need.imm_size = (r.cls == cls_mov_ri) ? op[3] : op[0];
    // d bit picks direction
    r.fields.src   = op[1] ? {1'b0, rm} : {1'b0, rg};
    r.fields.dst   = op[1] ? {1'b0, rg} : {1'b0, rm};
    r.fields.base  = reg_none;
    r.fields.index = reg_none;
    if (md != 2'b11) begin
      case (rm)
        3'd0: r.fields.base = reg_bx;
        3'd1: r.fields.base = reg_bx;
        3'd2: r.fields.base = reg_bp;
        3'd3: r.fields.base = reg_bp;
        3'd4: r.fields.base = reg_si;
        3'd5: r.fields.base = reg_di;
        3'd6: r.fields.base = (md == 2'b00) ? reg_none : reg_bp;
        default: r.fields.base = reg_bx;
      endcase
      if (rm <= 3'd3)
        r.fields.index = rm[0] ? reg_di : reg_si;
      bp = (r.fields.base == reg_bp);
    end
    r.fields.seg = sop[2] ? seg_t'(sop[1:0]) : (bp ? ss : ds);
    r.f = op[7] ? mrm[5:3] : op[5:3];
    return r;
  endfunction

  task automatic compare_port(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      m_off   <= '0;
      m_cnt   <= 5'd0;
      m_dive  <= 1'b0;
      m_ext   <= 1'b0;
      m_ext_q <= 1'b0;
      m_inta  <= 1'b0;
    end else begin
      exp_dec = ref_decode(opcode, modrm, sop_l);
      // redirect order is divide error, interrupt, class
      if (m_dive)
        exp_base = ent_intd;
      else if (m_ext)
        exp_base = rep ? ent_eintp : ent_eint;
      else
        exp_base = exp_dec.entry;
      exp_addr = exp_base + m_off;
      exp_end  = last_word(exp_addr);
      exp_div  = div_word(exp_addr);
      compare_port("need", 32'(need), 32'(exp_dec.need));
      compare_port("fields", 32'(fields), 32'(exp_dec.fields));
      compare_port("f", 32'(f), 32'(exp_dec.f));
      compare_port("seq_addr", 32'(seq_addr), 32'(exp_addr));
      compare_port("uword.end_seq", 32'(uword.end_seq), 32'(exp_end));
      compare_port("uword.div", 32'(uword.div), 32'(exp_div));
      compare_port("ext_int", 32'(ext_int), 32'(m_ext));
      compare_port("inta", 32'(inta), 32'(m_inta));
      // micro operation must be one of the defined codes
      checks++;
      if (uword.uop > uop_trap) begin
        errs++;
        $display("ERROR %0t uword.uop got %h, no such micro operation", $time, uword.uop);
      end
      // offset walk
      if (block)
        m_off <= m_off;
      else if (exp_end)
        m_off <= '0;
      else if (m_cnt != 5'd0)
        m_off <= m_off;
      else if (exec_st)
        m_off <= m_off + 6'd1;
      else
        m_off <= '0;
      if (exp_div && exec_st)
        m_cnt <= (m_cnt == 5'd0) ? div_stall : m_cnt - 5'd1;
      else
        m_cnt <= 5'd0;
      // redirect flags freeze under block
      if (!block) begin
        m_dive <= div_exc | (m_dive & ~exp_end);
        m_ext  <= (intr & ifl & exec_st & exp_end) | (m_ext & ~exp_end);
      end
      m_ext_q <= m_ext;
      m_inta  <= m_ext & ~m_ext_q;
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_decode_top.sv
/*
 * testbench for the decode stage: random then directed instructions,
 * driven on the falling edge, checked by the decode_checker monitor
 */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;
  import x86_isa_pkg::*;
  import micro_seq_pkg::*;

  localparam int n_random     = 300;
  localparam int n_directed   = 14;
  localparam int n_instr      = n_random + n_directed;
  localparam int reset_cycles = 16;
  localparam int instr_limit  = 200;

  logic            clk;
  logic            rst;
  logic [7:0]      opcode;
  logic [7:0]      modrm;
  logic            rep;
  logic [2:0]      sop_l;
  logic            exec_st;
  logic            block;
  logic            div_exc;
  logic            intr;
  logic            ifl;
  operand_need_t   need;
  operand_fields_t fields;
  logic [2:0]      f;
  micro_addr_t     seq_addr;
  micro_word_t     uword;
  logic            inta;
  logic            ext_int;
  int              err_cnt;
  int              chk_cnt;
  int              other_errs;
  logic [31:0]     lfsr;
  // a sequence ended at the last rising edge
  logic            seq_end;

  decode_top decode_top_i (
    .clk(clk), .rst(rst), .opcode(opcode), .modrm(modrm), .rep(rep), .sop_l(sop_l),
    .exec_st(exec_st), .block(block), .div_exc(div_exc), .intr(intr), .ifl(ifl),
    .need(need), .fields(fields), .f(f), .seq_addr(seq_addr), .uword(uword),
    .inta(inta), .ext_int(ext_int)
  );

  decode_checker mon_i (
    .clk(clk), .rst(rst), .opcode(opcode), .modrm(modrm), .rep(rep), .sop_l(sop_l),
    .exec_st(exec_st), .block(block), .div_exc(div_exc), .intr(intr), .ifl(ifl),
    .need(need), .fields(fields), .f(f), .seq_addr(seq_addr), .uword(uword),
    .inta(inta), .ext_int(ext_int), .err_cnt(err_cnt), .chk_cnt(chk_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst)
      seq_end <= 1'b0;
    else
      seq_end <= exec_st & ~block & uword.end_seq;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // hold one instruction until its sequence ends, then one idle cycle
  task automatic run_instr(input logic [7:0] op, input logic [7:0] mrm, input logic rp,
                           input logic [2:0] sop, input logic irq, input logic ie,
                           input logic use_block, input int exc_at);
    logic [31:0] r;
    int          cyc;
    cyc = 0;
    @(negedge clk);
    opcode  = op;
    modrm   = mrm;
    rep     = rp;
    sop_l   = sop;
    intr    = irq;
    ifl     = ie;
    exec_st = 1'b1;
    while (1'b1) begin
      block   = 1'b0;
      div_exc = (cyc == exc_at);
      if (use_block) begin
        draw(3, r);
        block = (r[2:0] == 3'd0);
      end
      @(negedge clk);
      cyc++;
      if (seq_end)
        break;
      if (cyc > instr_limit) begin
        other_errs++;
        $display("instruction %h did not reach the end of its sequence", op);
        break;
      end
    end
    exec_st = 1'b0;
    block   = 1'b0;
    div_exc = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0]  op;
    logic [7:0]  mrm;
    logic        rp;
    logic [2:0]  sop;
    logic        irq;
    int          n;
    rst        = 1'b1;
    opcode     = 8'h00;
    modrm      = 8'h00;
    rep        = 1'b0;
    sop_l      = 3'd0;
    exec_st    = 1'b0;
    block      = 1'b0;
    div_exc    = 1'b0;
    intr       = 1'b0;
    ifl        = 1'b0;
    other_errs = 0;
    lfsr       = 32'h64e9171d;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // random stream, invalid bytes included
    for (n = 0; n < n_random; n++) begin
      draw(8, r);
      op = r[7:0];
      draw(8, r);
      mrm = r[7:0];
      draw(1, r);
      rp = r[0];
      draw(3, r);
      sop = r[2:0];
      draw(2, r);
      irq = &r[1:0];
      draw(1, r);
      run_instr(op, mrm, rp, sop, irq, r[0], 1'b1, -1);
    end
    // each class, then divide, div_exc, block and interrupts
    run_instr(8'h01, 8'hc1, 1'b0, 3'b000, 1'b0, 1'b0, 1'b0, -1);
    run_instr(8'h03, 8'h46, 1'b0, 3'b000, 1'b0, 1'b0, 1'b0, -1);
    run_instr(8'h05, 8'h00, 1'b0, 3'b000, 1'b0, 1'b0, 1'b0, -1);
    run_instr(8'h89, 8'h06, 1'b0, 3'b101, 1'b0, 1'b0, 1'b0, -1);
    run_instr(8'hb8, 8'h00, 1'b0, 3'b000, 1'b0, 1'b0, 1'b0, -1);
    run_instr(8'h83, 8'h80, 1'b0, 3'b000, 1'b0, 1'b0, 1'b0, -1);
    run_instr(8'hf7, 8'h92, 1'b0, 3'b000, 1'b0, 1'b0, 1'b0, -1);
    run_instr(8'hf7, 8'hf3, 1'b0, 3'b000, 1'b0, 1'b0, 1'b0, -1);
    run_instr(8'hf6, 8'hf8, 1'b0, 3'b000, 1'b0, 1'b0, 1'b1, -1);
    run_instr(8'hf7, 8'hf1, 1'b0, 3'b000, 1'b0, 1'b0, 1'b0, 5);
    run_instr(8'heb, 8'h00, 1'b0, 3'b000, 1'b0, 1'b0, 1'b0, -1);
    // rep set, so the interrupt enters at ent_eintp
    run_instr(8'h90, 8'h00, 1'b1, 3'b000, 1'b1, 1'b1, 1'b0, -1);
    run_instr(8'h0f, 8'h00, 1'b1, 3'b000, 1'b1, 1'b0, 1'b0, -1);
    run_instr(8'h8b, 8'h5a, 1'b0, 3'b000, 1'b0, 1'b0, 1'b1, -1);
    repeat (4) @(negedge clk);
    if (chk_cnt == 0) begin
      other_errs++;
      $display("monitor made no comparisons");
    end
    $display("errors: %0d mismatches, %0d other, %0d checks", err_cnt, other_errs, chk_cnt);
    if (err_cnt == 0 && other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog, 40 cycles per instruction plus reset
  initial begin
    repeat (n_instr * 40 + reset_cycles) @(posedge clk);
    $display("timeout: instruction stream did not finish in time");
    $display("errors: %0d mismatches, %0d other, %0d checks", err_cnt, other_errs + 1,
             chk_cnt);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- micro_decode.f
+incdir+include
src/x86_isa_pkg.sv
src/micro_seq_pkg.sv
src/opcode_deco.sv
src/instr_decode.sv
src/micro_rom.sv
src/decode_top.sv
tests/decode_checker.sv
tests/tb_decode_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = tb_decode_top
FILELIST  = micro_decode.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
